// File: build.f
+incdir+verilog
verilog/memPipePkg.sv
verilog/cmdStage.sv
verilog/dualPortRam.sv
verilog/readbackStage.sv
verilog/memPipeTop.sv
verif/memPipe_asserts.sv
verif/memPipeChecker.sv
verif/memPipeTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the memory pipeline testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module memPipeTb -f build.f -o simMemPipe
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output="$(./obj_dir/simMemPipe +verilator+error+limit+100)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
	exit 0
else
	exit 1
fi

// File: verif/memPipeTb.sv
// Testbench top for the memory exerciser pipeline
// Offers a table of commands under random back-pressure; memPipeChecker compares the results

`timescale 1ns/1ps
`default_nettype none

`include "memPipe_params.svh"

module memPipeTb;

	import memPipePkg::*;

	localparam int NumTests = 17;
	// Eight cycles per entry covers heavy stalling, plus pipeline fill
	localparam int TimeoutCycles = NumTests * 8 + 100;

	logic     clk;
	logic     rst;
	logic     cmdValid;
	logic     cmdReady;
	memCmd    cmd;
	logic     resValid;
	logic     resReady;
	memResult res;

	// Command table, one row per test
	logic [63:0]            testName [NumTests];
	memCmd                  testCmd [NumTests];
	logic [`MEM_DATA_W-1:0] testExp [NumTests];
	int                     tableFill;

	logic [31:0] rngState;
	int          passCount;
	int          failCount;
	int          resultCount;

	always #20 clk = ~clk;

	memPipeTop u_dut (
		.clk      (clk),
		.rst      (rst),
		.cmdValid (cmdValid),
		.cmdReady (cmdReady),
		.cmd      (cmd),
		.resValid (resValid),
		.resReady (resReady),
		.res      (res)
	);

	memPipeChecker #(.NumTests(NumTests)) uChecker (
		.clk         (clk),
		.rst         (rst),
		.resValid    (resValid),
		.resReady    (resReady),
		.res         (res),
		.testName    (testName),
		.testCmd     (testCmd),
		.testExp     (testExp),
		.passCount   (passCount),
		.failCount   (failCount),
		.resultCount (resultCount)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Addresses are taken as int so that values past 255 wrap like the hardware
	function automatic memCmd makeCmd(input memOp opA, input int addrA,
			input logic [`MEM_DATA_W-1:0] dataA, input memOp opB, input int addrB,
			input logic [`MEM_DATA_W-1:0] dataB, input logic portSel);
		memCmd c;
		c.opA = opA;
		c.opB = opB;
		c.addrA = addrA[`MEM_ADDR_W-1:0];
		c.addrB = addrB[`MEM_ADDR_W-1:0];
		c.dataA = dataA;
		c.dataB = dataB;
		c.portSel = portSel;
		return c;
	endfunction

	task automatic addEntry(input logic [63:0] name, input memCmd c,
			input logic [`MEM_DATA_W-1:0] expData);
		testName[tableFill] = name;
		testCmd[tableFill] = c;
		testExp[tableFill] = expData;
		tableFill++;
	endtask

	// Expected words follow read-before-write and port B winning a conflict
	// Unwritten words read as the power-up zero
	task automatic loadTable();
		tableFill = 0;
		addEntry("wrA     ", makeCmd(opWrite, 'h10, 16'h1234, opRead, 'h10, 16'h0, 1'b0), 16'h0000);
		addEntry("rdA     ", makeCmd(opRead, 'h10, 16'h0, opRead, 'h10, 16'h0, 1'b0), 16'h1234);
		addEntry("wrB     ", makeCmd(opRead, 'h20, 16'h0, opWrite, 'h20, 16'hbeef, 1'b1), 16'h0000);
		addEntry("rdB     ", makeCmd(opRead, 'h20, 16'h0, opRead, 'h20, 16'h0, 1'b1), 16'hbeef);
		addEntry("rbwOld  ", makeCmd(opWrite, 'h10, 16'h5a5a, opRead, 'h10, 16'h0, 1'b1), 16'h1234);
		addEntry("rbwNew  ", makeCmd(opRead, 'h10, 16'h0, opRead, 'h10, 16'h0, 1'b1), 16'h5a5a);
		addEntry("confWr  ", makeCmd(opWrite, 'h30, 16'h1111, opWrite, 'h30, 16'h2222, 1'b0), 16'h0000);
		addEntry("confRd  ", makeCmd(opRead, 'h30, 16'h0, opRead, 'h30, 16'h0, 1'b0), 16'h2222);
		// Clear ignores its data field
		addEntry("clear   ", makeCmd(opClear, 'h20, 16'hffff, opRead, 'h20, 16'h0, 1'b1), 16'hbeef);
		addEntry("clearRd ", makeCmd(opRead, 'h20, 16'h0, opRead, 'h20, 16'h0, 1'b0), 16'h0000);
		// 513 and 257 both land on word 1
		addEntry("wrapWr  ", makeCmd(opWrite, 513, 16'h0abc, opRead, 1, 16'h0, 1'b0), 16'h0000);
		addEntry("wrapRd  ", makeCmd(opRead, 1, 16'h0, opRead, 257, 16'h0, 1'b1), 16'h0abc);
		addEntry("selA    ", makeCmd(opRead, 'h10, 16'h0, opRead, 'h30, 16'h0, 1'b0), 16'h5a5a);
		addEntry("selB    ", makeCmd(opRead, 'h10, 16'h0, opRead, 'h30, 16'h0, 1'b1), 16'h2222);
		addEntry("wrBoth  ", makeCmd(opWrite, 'h40, 16'h00f7, opWrite, 'h41, 16'h0e3c, 1'b0), 16'h0000);
		addEntry("crossB  ", makeCmd(opRead, 'h41, 16'h0, opRead, 'h40, 16'h0, 1'b1), 16'h00f7);
		addEntry("crossA  ", makeCmd(opRead, 'h41, 16'h0, opRead, 'h40, 16'h0, 1'b0), 16'h0e3c);
	endtask

	// Consumer ready on about three cycles in four
	always @(posedge clk) begin
		#2;
		rngState = xorshift(rngState);
		resReady = (rngState[1:0] != 2'b00);
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		cmdValid = 1'b0;
		cmd = '0;
		resReady = 1'b0;
		rngState = 32'h57d5511e;
		loadTable();
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;
		for (int i = 0; i < NumTests; i++) begin
			cmdValid = 1'b1;
			cmd = testCmd[i];
			// Ready seen at the falling edge means the transfer happens on the next rise
			do @(negedge clk); while (!cmdReady);
			@(posedge clk);
			#2;
		end
		cmdValid = 1'b0;
		cmd = '0;
		wait (resultCount >= NumTests);
		// Leave time for any stray extra result
		repeat (10) @(posedge clk);
		$display("Summary: %0d passed, %0d failed, %0d assertion failures",
			passCount, failCount, u_dut.uAsserts.violations);
		if (passCount == NumTests && failCount == 0 && u_dut.uAsserts.violations == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (TimeoutCycles + 16) @(posedge clk);
		$display("Timeout: results are missing, %0d of %0d arrived", resultCount, NumTests);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/memPipeChecker.sv
// Result monitor for the memory pipeline testbench
// Takes result transfers in order and compares each with its row of the command table

`timescale 1ns/1ps
`default_nettype none

`include "memPipe_params.svh"

module memPipeChecker #(
	parameter int NumTests = 1
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   resValid,
	input  logic                   resReady,
	input  memPipePkg::memResult   res,
	input  logic [63:0]            testName [NumTests],
	input  memPipePkg::memCmd      testCmd [NumTests],
	input  logic [`MEM_DATA_W-1:0] testExp [NumTests],
	output int                     passCount,
	output int                     failCount,
	output int                     resultCount
);

	import memPipePkg::*;

	logic [6:0] expSeg;

	// Lit segments of each hex digit, as letters a to g
	// Result is active low with segment a in bit 0
	function automatic logic [6:0] segmentsFor(input logic [3:0] digit);
		string      lit;
		logic [6:0] pattern;
		case (digit)
			4'h0: lit = "abcdef";
			4'h1: lit = "bc";
			4'h2: lit = "abdeg";
			4'h3: lit = "abcdg";
			4'h4: lit = "bcfg";
			4'h5: lit = "acdfg";
			4'h6: lit = "acdefg";
			4'h7: lit = "abc";
			4'h8: lit = "abcdefg";
			4'h9: lit = "abcdfg";
			4'ha: lit = "abcefg";
			4'hb: lit = "cdefg";
			4'hc: lit = "adef";
			4'hd: lit = "bcdeg";
			4'he: lit = "adefg";
			default: lit = "aefg";
		endcase
		pattern = 7'h7f;
		for (int i = 0; i < lit.len(); i++) begin
			pattern = pattern & ~(7'd1 << (lit[i] - 8'd97));
		end
		return pattern;
	endfunction

	initial begin
		passCount = 0;
		failCount = 0;
		resultCount = 0;
	end

	// Handshake sampled at the falling edge, where everything is settled
	// A match here completes on the following rising edge
	always @(negedge clk) begin
		if (!rst && resValid && resReady) begin
			if (resultCount >= NumTests) begin
				$display("Extra result arrived after the last test, data %h", res.data);
				failCount++;
			end else begin
				expSeg = segmentsFor(testExp[resultCount][3:0]);
				if (res.data !== testExp[resultCount]) begin
					$display("FAILED %s expected %h actual %h",
						testName[resultCount], testExp[resultCount], res.data);
					failCount++;
				end else if (res.segments !== expSeg) begin
					$display("FAILED %s segments expected %b actual %b",
						testName[resultCount], expSeg, res.segments);
					failCount++;
				end else if (res.portSel !== testCmd[resultCount].portSel) begin
					$display("FAILED %s portSel expected %b actual %b",
						testName[resultCount], testCmd[resultCount].portSel, res.portSel);
					failCount++;
				end else begin
					$display("PASSED %s data %h", testName[resultCount], res.data);
					passCount++;
				end
			end
			resultCount++;
		end
	end

endmodule

`default_nettype wire

// File: verif/memPipe_asserts.sv
// Handshake and reset assertions for the memory pipeline
// Bound into memPipeTop below

`timescale 1ns/1ps
`default_nettype none

module memPipeAsserts (
	input logic                 clk,
	input logic                 rst,
	input logic                 resValid,
	input logic                 resReady,
	input memPipePkg::memResult res
);

	// Number of failed assertions
	int violations = 0;

	// Output holds while the consumer stalls
	assert property (@(posedge clk) disable iff (rst)
		resValid && !resReady |=> resValid && $stable(res))
	else begin
		$error("Result changed while stalled");
		violations++;
	end

	// Synchronous reset empties the output register
	assert property (@(posedge clk) rst |=> !resValid)
	else begin
		$error("resValid high after a reset cycle");
		violations++;
	end

	assert property (@(posedge clk) disable iff (rst) resValid |-> !$isunknown(res))
	else begin
		$error("Result has unknown bits while valid");
		violations++;
	end

endmodule

bind memPipeTop memPipeAsserts uAsserts (
	.clk      (clk),
	.rst      (rst),
	.resValid (resValid),
	.resReady (resReady),
	.res      (res)
);

`default_nettype wire

// File: verilog/memPipeTop.sv
// Top level of the dual-port memory exerciser pipeline
// Command in, result out, both under valid/ready; three results can be in flight

`timescale 1ns/1ps
`default_nettype none

`include "memPipe_params.svh"

module memPipeTop (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 cmdValid,
	output logic                 cmdReady,
	input  memPipePkg::memCmd    cmd,
	output logic                 resValid,
	input  logic                 resReady,
	output memPipePkg::memResult res
);

	import memPipePkg::*;

	// Common stall for all three stages
	logic advance;

	// Command stage to RAM
	ramPortReq reqA;
	ramPortReq reqB;
	logic      stValid;
	logic      stPortSel;

	// RAM to readback stage
	logic [`MEM_DATA_W-1:0] rdataA;
	logic [`MEM_DATA_W-1:0] rdataB;
	logic                   ramValid;
	logic                   ramPortSel;

	// Output register is empty or draining this cycle
	assign advance = !resValid || resReady;
	assign cmdReady = advance;

	cmdStage uCmdStage (
		.clk       (clk),
		.rst       (rst),
		.advance   (advance),
		.cmdValid  (cmdValid),
		.cmd       (cmd),
		.reqA      (reqA),
		.reqB      (reqB),
		.stValid   (stValid),
		.stPortSel (stPortSel)
	);

	dualPortRam uRam (
		.clk        (clk),
		.rst        (rst),
		.advance    (advance),
		.reqA       (reqA),
		.reqB       (reqB),
		.inValid    (stValid),
		.inPortSel  (stPortSel),
		.rdataA     (rdataA),
		.rdataB     (rdataB),
		.outValid   (ramValid),
		.outPortSel (ramPortSel)
	);

	readbackStage uReadback (
		.clk       (clk),
		.rst       (rst),
		.advance   (advance),
		.inValid   (ramValid),
		.inPortSel (ramPortSel),
		.rdataA    (rdataA),
		.rdataB    (rdataB),
		.resValid  (resValid),
		.res       (res)
	);

endmodule

`default_nettype wire

// File: verilog/readbackStage.sv
// Output stage of the memory pipeline
// Picks the selected port's read word and shows its low nibble on a 7-segment digit
// The result register holds while the consumer is not ready

`timescale 1ns/1ps
`default_nettype none

`include "memPipe_params.svh"

module readbackStage (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   advance,
	input  logic                   inValid,
	input  logic                   inPortSel,
	input  logic [`MEM_DATA_W-1:0] rdataA,
	input  logic [`MEM_DATA_W-1:0] rdataB,
	output logic                   resValid,
	output memPipePkg::memResult   res
);

	import memPipePkg::*;

	// Result formed from the current RAM outputs
	memResult nextRes;

	// Selected read word
	logic [`MEM_DATA_W-1:0] selData;

	// Hex digit to segment pattern
	// Active low, bit 0 is segment a, bit 6 is segment g
	function automatic logic [6:0] hexSegments(input logic [3:0] nibble);
		logic [6:0] litSegs;
		case (nibble)
			4'h0: litSegs = 7'h3f;
			4'h1: litSegs = 7'h06;
			4'h2: litSegs = 7'h5b;
			4'h3: litSegs = 7'h4f;
			4'h4: litSegs = 7'h66;
			4'h5: litSegs = 7'h6d;
			4'h6: litSegs = 7'h7d;
			4'h7: litSegs = 7'h07;
			4'h8: litSegs = 7'h7f;
			4'h9: litSegs = 7'h6f;
			4'ha: litSegs = 7'h77;
			4'hb: litSegs = 7'h7c;
			4'hc: litSegs = 7'h39;
			4'hd: litSegs = 7'h5e;
			4'he: litSegs = 7'h79;
			default: litSegs = 7'h71;
		endcase
		// Table above lists lit segments as ones
		return ~litSegs;
	endfunction

	// Port select, 0 for A and 1 for B
	assign selData = inPortSel ? rdataB : rdataA;

	// Assemble the result word
	always_comb begin
		nextRes.data = selData;
		nextRes.portSel = inPortSel;
		nextRes.segments = hexSegments(selData[3:0]);
	end

	// Output payload
	// Loaded only when the register is empty or being drained
	always_ff @(posedge clk) begin
		if (advance) begin
			res <= nextRes;
		end
	end

	// Valid drops after a transfer with nothing valid behind it
	// and holds high while stalled
	always_ff @(posedge clk) begin
		if (rst) begin
			resValid <= 1'b0;
		end else if (advance) begin
			resValid <= inValid;
		end
	end

endmodule

`default_nettype wire

// File: verilog/dualPortRam.sv
// True dual-port synchronous RAM stage with registered read data
// Both ports read before they write; port B wins a same-address write

`timescale 1ns/1ps
`default_nettype none

`include "memPipe_params.svh"

module dualPortRam (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   advance,
	input  memPipePkg::ramPortReq  reqA,
	input  memPipePkg::ramPortReq  reqB,
	input  logic                   inValid,
	input  logic                   inPortSel,
	output logic [`MEM_DATA_W-1:0] rdataA,
	output logic [`MEM_DATA_W-1:0] rdataB,
	output logic                   outValid,
	output logic                   outPortSel
);

	// Storage array
	logic [`MEM_DATA_W-1:0] mem [`MEM_DEPTH];

	// Power-up contents are zero
	// rst leaves the array alone
	initial begin
		for (int i = 0; i < `MEM_DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	// Reads and writes share one clocked block
	// Nonblocking reads see the array as it was before this edge
	// so each port gets the old word even when either port writes it
	always_ff @(posedge clk) begin
		if (advance) begin
			rdataA <= mem[reqA.addr];
			rdataB <= mem[reqB.addr];

			// Port A first
			if (reqA.we) begin
				mem[reqA.addr] <= reqA.wdata;
			end

			// Port B last, so its data stays on a conflict
			if (reqB.we) begin
				mem[reqB.addr] <= reqB.wdata;
			end
		end
	end

	// Port select rides alongside the read data
	always_ff @(posedge clk) begin
		if (advance) begin
			outPortSel <= inPortSel;
		end
	end

	// Only the valid flag is cleared by reset
	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (advance) begin
			outValid <= inValid;
		end
	end

endmodule

`default_nettype wire

// File: verilog/cmdStage.sv
// Input stage of the memory pipeline
// Registers one command per transfer and decodes it into two RAM port requests

`timescale 1ns/1ps
`default_nettype none

module cmdStage (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  advance,
	input  logic                  cmdValid,
	input  memPipePkg::memCmd     cmd,
	output memPipePkg::ramPortReq reqA,
	output memPipePkg::ramPortReq reqB,
	output logic                  stValid,
	output logic                  stPortSel
);

	import memPipePkg::*;

	// Captured command, payload only
	memCmd cmdReg;

	// Set when cmdReg holds a command that still has to reach the RAM
	logic validReg;

	// Valid flag follows the handshake
	// cmdReady equals advance, so a capture here is a transfer
	always_ff @(posedge clk) begin
		if (rst) begin
			validReg <= 1'b0;
		end else if (advance) begin
			validReg <= cmdValid;
		end
	end

	// Payload is loaded on every advance, valid or not
	always_ff @(posedge clk) begin
		if (advance) begin
			cmdReg <= cmd;
		end
	end

	// Port A decode
	// Write and clear both write, clear forces zero data
	always_comb begin
		reqA.addr = cmdReg.addrA;
		reqA.we = validReg && (cmdReg.opA == opWrite || cmdReg.opA == opClear);
		if (cmdReg.opA == opClear) begin
			reqA.wdata = '0;
		end else begin
			reqA.wdata = cmdReg.dataA;
		end
	end

	// Port B decode, same rules as port A
	always_comb begin
		reqB.addr = cmdReg.addrB;
		reqB.we = validReg && (cmdReg.opB == opWrite || cmdReg.opB == opClear);
		if (cmdReg.opB == opClear) begin
			reqB.wdata = '0;
		end else begin
			reqB.wdata = cmdReg.dataB;
		end
	end

	// Sideband travels with the requests into the RAM stage
	assign stValid = validReg;
	assign stPortSel = cmdReg.portSel;

endmodule

`default_nettype wire

// File: verilog/memPipePkg.sv
// Shared types for the memory exerciser pipeline
// Modules import this package for opcodes and the command and result structs

`default_nettype none

`include "memPipe_params.svh"

package memPipePkg;

	// Per-port operation carried in every command
	typedef enum logic [1:0] {
		opRead  = 2'd0,
		opWrite = 2'd1,
		opClear = 2'd2
	} memOp;

	// One command drives both RAM ports at once
	// portSel picks which port's read word reaches the output
	typedef struct packed {
		memOp                   opA;
		memOp                   opB;
		logic [`MEM_ADDR_W-1:0] addrA;
		logic [`MEM_ADDR_W-1:0] addrB;
		logic [`MEM_DATA_W-1:0] dataA;
		logic [`MEM_DATA_W-1:0] dataB;
		logic                   portSel;
	} memCmd;

	// Result word as seen at the pipeline output
	// Segments are active low with segment a in bit 0
	typedef struct packed {
		logic [`MEM_DATA_W-1:0] data;
		logic                   portSel;
		logic [6:0]             segments;
	} memResult;

	// Decoded request for one RAM port
	typedef struct packed {
		logic                   we;
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`MEM_DATA_W-1:0] wdata;
	} ramPortReq;

endpackage

`default_nettype wire

// File: verilog/memPipe_params.svh
// Width and depth macros for the memory exerciser pipeline
// Include in any file that sizes data, addresses or the RAM array

`ifndef MEM_PIPE_PARAMS_SVH
`define MEM_PIPE_PARAMS_SVH

// Width of one RAM word and of each port's write data
`define MEM_DATA_W 16

// Address width for both ports
// Wider values wrap, so 513 lands on word 1
`define MEM_ADDR_W 8

// Number of words in the RAM
`define MEM_DEPTH 256

`endif
